/* source/note_pkg.sv */
package note_pkg;

  //////////////////////////////////////////////////////////////////////
  // operating modes
  //////////////////////////////////////////////////////////////////////

  // idle, keys pass straight through
  localparam logic [1:0] mode_user = 2'd0;
  // every sample tick stores the live keys
  localparam logic [1:0] mode_record = 2'd1;
  // every sample tick replays the next stored word
  localparam logic [1:0] mode_playback = 2'd2;

  //////////////////////////////////////////////////////////////////////
  // default build sizes
  //////////////////////////////////////////////////////////////////////

  // keys on the board row
  localparam int default_key_count = 17;
  // take memory depth is 2**addr_width words
  localparam int default_addr_width = 9;
  // about 10 ms at 27 MHz
  localparam int default_stable_cycles = 270000;

  // volume setting and its limits
  localparam int volume_width = 5;
  localparam int volume_reset = 8;
  localparam int volume_max = 31;

endpackage

/* source/key_debouncer.sv */
`timescale 1ns/1ps

module key_debouncer #(
  parameter int stable_cycles = note_pkg::default_stable_cycles
) (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // wide enough to reach stable_cycles
  localparam int count_width = $clog2(stable_cycles + 1);

  // last sampled level of the raw input
  logic held;
  // cycles the held level has stayed unchanged
  logic [count_width-1:0] count;
  logic expired;

  assign expired = (count == count_width'(stable_cycles));

  always_ff @(posedge clock) begin
    if (reset) begin
      // start out agreeing with the pin
      held <= noisy;
      count <= '0;
      clean <= noisy;
    end else if (noisy != held) begin
      // any bounce restarts the hold time
      held <= noisy;
      count <= '0;
    end else if (expired) begin
      clean <= held;
    end else begin
      count <= count + 1'b1;
    end
  end

  // the clean level only moves once the hold time has run out
  clean_after_hold: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) && (clean != $past(clean)) |-> $past(expired));

endmodule

/* source/volume_control.sv */
`timescale 1ns/1ps

module volume_control (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              up_clean,
  input  logic                              down_clean,
  output logic [note_pkg::volume_width-1:0] volume
);
  import note_pkg::*;

  logic up_last;
  logic down_last;
  logic up_edge;
  logic down_edge;

  // press edges of the debounced buttons
  assign up_edge = up_clean & ~up_last;
  assign down_edge = down_clean & ~down_last;

  always_ff @(posedge clock) begin
    up_last <= up_clean;
    down_last <= down_clean;
    if (reset) begin
      volume <= volume_width'(volume_reset);
    end else if (up_edge && !down_edge && volume != volume_width'(volume_max)) begin
      volume <= volume + 1'b1;
    end else if (down_edge && !up_edge && volume != '0) begin
      // both pressed at once cancel out
      volume <= volume - 1'b1;
    end
  end

  // stays within limits and moves one step at most
  volume_step: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) |-> (volume <= volume_max) && ((volume == $past(volume)) ||
      (volume == $past(volume) + 1) || (volume + 1 == $past(volume))));

endmodule

/* source/mode_control.sv */
`timescale 1ns/1ps

module mode_control #(
  parameter int addr_width = note_pkg::default_addr_width
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                sample_tick,
  input  logic                record_clean,
  input  logic                play_clean,
  input  logic [addr_width:0] write_addr,
  input  logic                play_done,
  output logic [1:0]          mode,
  output logic                record_start,
  output logic                play_start,
  output logic [addr_width:0] take_length
);
  import note_pkg::*;

  logic record_last;
  logic play_last;
  logic record_edge;
  logic play_edge;
  // presses waiting for the next tick
  logic record_pending;
  logic play_pending;
  logic take_full;
  logic take_empty;

  assign record_edge = record_clean & ~record_last;
  assign play_edge = play_clean & ~play_last;
  // msb of the write count is set once every address is used
  assign take_full = write_addr[addr_width];
  assign take_empty = (write_addr == '0);

  always_ff @(posedge clock) begin
    record_last <= record_clean;
    play_last <= play_clean;
  end

  //////////////////////////////////////////////////////////////////////
  // user / record / playback FSM stepped on sample ticks
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      mode <= mode_user;
      record_pending <= 1'b0;
      play_pending <= 1'b0;
      record_start <= 1'b0;
      play_start <= 1'b0;
      take_length <= '0;
    end else begin
      record_start <= 1'b0;
      play_start <= 1'b0;
      if (sample_tick) begin
        // an edge in the tick cycle waits for the following tick
        record_pending <= record_edge;
        play_pending <= play_edge;
        case (mode)
          mode_user: begin
            if (record_pending) begin
              mode <= mode_record;
              record_start <= 1'b1;
            end else if (play_pending && take_length != '0) begin
              mode <= mode_playback;
              play_start <= 1'b1;
            end
          end
          mode_record: begin
            if (play_pending && !take_empty) begin
              take_length <= write_addr;
              mode <= mode_playback;
              play_start <= 1'b1;
            end else if (record_pending || play_pending || take_full) begin
              take_length <= write_addr;
              mode <= mode_user;
            end
          end
          mode_playback: begin
            if (record_pending) begin
              mode <= mode_record;
              record_start <= 1'b1;
            end else if (play_done) begin
              mode <= mode_user;
            end
          end
          default: mode <= mode_user;
        endcase
      end else begin
        record_pending <= record_pending | record_edge;
        play_pending <= play_pending | play_edge;
      end
    end
  end

endmodule

/* source/take_recorder.sv */
`timescale 1ns/1ps

module take_recorder #(
  parameter int key_count = note_pkg::default_key_count,
  parameter int addr_width = note_pkg::default_addr_width
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 sample_tick,
  input  logic [1:0]           mode,
  input  logic                 record_start,
  input  logic [key_count-1:0] keys_clean,
  input  logic                 write_grant,
  output logic                 write_request,
  output logic [addr_width:0]  write_addr,
  output logic [key_count-1:0] write_keys
);
  import note_pkg::*;

  logic take_full;
  logic capture;

  // never wrap onto the start of the take
  assign take_full = write_addr[addr_width];
  assign capture = sample_tick && (mode == mode_record) && !take_full && !write_request;

  always_ff @(posedge clock) begin
    if (reset || record_start) begin
      write_request <= 1'b0;
      write_addr <= '0;
    end else if (write_grant) begin
      // the grant finishes the write
      write_request <= 1'b0;
      write_addr <= write_addr + 1'b1;
    end else if (capture) begin
      write_request <= 1'b1;
    end
  end

  // snapshot of the keys at the tick
  always_ff @(posedge clock) begin
    if (capture) begin
      write_keys <= keys_clean;
    end
  end

endmodule

/* source/take_player.sv */
`timescale 1ns/1ps

module take_player #(
  parameter int key_count = note_pkg::default_key_count,
  parameter int addr_width = note_pkg::default_addr_width
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 sample_tick,
  input  logic [1:0]           mode,
  input  logic                 play_start,
  input  logic [addr_width:0]  take_length,
  input  logic                 read_grant,
  input  logic [key_count-1:0] read_keys,
  output logic                 read_request,
  output logic [addr_width:0]  read_addr,
  output logic [key_count-1:0] keys_play,
  output logic                 play_done
);
  import note_pkg::*;

  // memory data lands the cycle after the grant
  logic fetch_pending;
  logic fetch;

  assign play_done = (mode == mode_playback) && (read_addr == take_length);
  assign fetch = sample_tick && (mode == mode_playback) && !play_done &&
                 !read_request && !fetch_pending;

  always_ff @(posedge clock) begin
    if (reset || play_start) begin
      read_request <= 1'b0;
      read_addr <= '0;
      fetch_pending <= 1'b0;
    end else begin
      if (read_grant) begin
        read_request <= 1'b0;
        fetch_pending <= 1'b1;
      end else if (fetch) begin
        // may wait behind a write
        read_request <= 1'b1;
      end
      if (fetch_pending) begin
        fetch_pending <= 1'b0;
        read_addr <= read_addr + 1'b1;
      end
    end
  end

  // replayed pattern, blank until the first word arrives
  always_ff @(posedge clock) begin
    if (play_start) begin
      keys_play <= '0;
    end else if (fetch_pending) begin
      keys_play <= read_keys;
    end
  end

endmodule

/* source/take_store.sv */
`timescale 1ns/1ps

module take_store #(
  parameter int key_count = note_pkg::default_key_count,
  parameter int addr_width = note_pkg::default_addr_width
) (
  input  logic                 clock,
  input  logic                 write_request,
  input  logic [addr_width:0]  write_addr,
  input  logic [key_count-1:0] write_keys,
  input  logic                 read_request,
  input  logic [addr_width:0]  read_addr,
  output logic                 write_grant,
  output logic                 read_grant,
  output logic [key_count-1:0] read_keys
);

  // one word of keys per sample tick
  logic [key_count-1:0] memory [2**addr_width];
  // shared address of the single port
  logic [addr_width-1:0] port_addr;

  //////////////////////////////////////////////////////////////////////
  // fixed priority arbiter
  //////////////////////////////////////////////////////////////////////

  // recorder always wins, player waits
  assign write_grant = write_request;
  assign read_grant = read_request & ~write_request;

  // msb of the counters only marks a full take
  assign port_addr = write_grant ? write_addr[addr_width-1:0] : read_addr[addr_width-1:0];

  //////////////////////////////////////////////////////////////////////
  // single port memory
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (write_grant) begin
      memory[port_addr] <= write_keys;
    end else if (read_grant) begin
      // registered read, data the cycle after the grant
      read_keys <= memory[port_addr];
    end
  end

  // only one peer owns the port in a cycle
  grant_exclusive: assert property (@(posedge clock)
    !(write_grant && read_grant));

  // a grant ends the request, so the requester drops it at once
  grant_single_cycle: assert property (@(posedge clock)
    (write_grant |=> !write_grant) and (read_grant |=> !read_grant));

endmodule

/* source/note_recorder_top.sv */
`timescale 1ns/1ps

module note_recorder_top #(
  parameter int key_count = note_pkg::default_key_count,
  parameter int addr_width = note_pkg::default_addr_width,
  parameter int stable_cycles = note_pkg::default_stable_cycles
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              sample_tick,
  input  logic [key_count-1:0]              keys_raw,
  input  logic                              record_raw,
  input  logic                              play_raw,
  input  logic                              up_raw,
  input  logic                              down_raw,
  output logic [key_count-1:0]              keys_out,
  output logic [1:0]                        mode,
  output logic [note_pkg::volume_width-1:0] volume
);
  import note_pkg::*;

  // debounced levels
  logic [key_count-1:0] keys_clean;
  logic record_clean;
  logic play_clean;
  logic up_clean;
  logic down_clean;

  // mode control strobes and take size
  logic record_start;
  logic play_start;
  logic [addr_width:0] take_length;
  logic play_done;

  // recorder side of the take memory
  logic write_request;
  logic write_grant;
  logic [addr_width:0] write_addr;
  logic [key_count-1:0] write_keys;

  // player side of the take memory
  logic read_request;
  logic read_grant;
  logic [addr_width:0] read_addr;
  logic [key_count-1:0] read_keys;
  logic [key_count-1:0] keys_play;

  //////////////////////////////////////////////////////////////////////
  // input debouncers
  //////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < key_count; i++) begin : g_key
    key_debouncer #(.stable_cycles(stable_cycles)) u_key_debouncer (
      .clock(clock), .reset(reset), .noisy(keys_raw[i]), .clean(keys_clean[i]));
  end

  key_debouncer #(.stable_cycles(stable_cycles)) u_record_debouncer (
    .clock(clock), .reset(reset), .noisy(record_raw), .clean(record_clean));
  key_debouncer #(.stable_cycles(stable_cycles)) u_play_debouncer (
    .clock(clock), .reset(reset), .noisy(play_raw), .clean(play_clean));
  key_debouncer #(.stable_cycles(stable_cycles)) u_up_debouncer (
    .clock(clock), .reset(reset), .noisy(up_raw), .clean(up_clean));
  key_debouncer #(.stable_cycles(stable_cycles)) u_down_debouncer (
    .clock(clock), .reset(reset), .noisy(down_raw), .clean(down_clean));

  //////////////////////////////////////////////////////////////////////
  // control and take datapath
  //////////////////////////////////////////////////////////////////////
  volume_control u_volume_control (
    .clock(clock), .reset(reset), .up_clean(up_clean), .down_clean(down_clean),
    .volume(volume));

  mode_control #(.addr_width(addr_width)) u_mode_control (
    .clock(clock), .reset(reset), .sample_tick(sample_tick),
    .record_clean(record_clean), .play_clean(play_clean), .write_addr(write_addr),
    .play_done(play_done), .mode(mode), .record_start(record_start),
    .play_start(play_start), .take_length(take_length));

  take_recorder #(.key_count(key_count), .addr_width(addr_width)) u_take_recorder (
    .clock(clock), .reset(reset), .sample_tick(sample_tick), .mode(mode),
    .record_start(record_start), .keys_clean(keys_clean), .write_grant(write_grant),
    .write_request(write_request), .write_addr(write_addr), .write_keys(write_keys));

  take_player #(.key_count(key_count), .addr_width(addr_width)) u_take_player (
    .clock(clock), .reset(reset), .sample_tick(sample_tick), .mode(mode),
    .play_start(play_start), .take_length(take_length), .read_grant(read_grant),
    .read_keys(read_keys), .read_request(read_request), .read_addr(read_addr),
    .keys_play(keys_play), .play_done(play_done));

  take_store #(.key_count(key_count), .addr_width(addr_width)) u_take_store (
    .clock(clock), .write_request(write_request), .write_addr(write_addr),
    .write_keys(write_keys), .read_request(read_request), .read_addr(read_addr),
    .write_grant(write_grant), .read_grant(read_grant), .read_keys(read_keys));

  // replayed keys only during playback, live keys otherwise
  assign keys_out = (mode == mode_playback) ? keys_play : keys_clean;

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
  parameter int key_count = 8,
  parameter int addr_width = 4,
  parameter int stable_cycles = 4
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 sample_tick,
  input  logic [key_count-1:0] keys_raw,
  input  logic                 record_raw,
  input  logic                 play_raw,
  input  logic                 up_raw,
  input  logic                 down_raw,
  input  logic [key_count-1:0] keys_out,
  input  logic [1:0]           mode,
  input  logic [4:0]           volume,
  output int                   check_count,
  output int                   error_count
);

  localparam int input_count = key_count + 4;
  localparam int depth = 2 ** addr_width;
  // buttons sit above the keys in the raw vector
  localparam int record_bit = key_count;
  localparam int play_bit = key_count + 1;
  localparam int up_bit = key_count + 2;
  localparam int down_bit = key_count + 3;
  localparam logic [1:0] user_code = 2'd0;
  localparam logic [1:0] record_code = 2'd1;
  localparam logic [1:0] playback_code = 2'd2;

  logic [input_count-1:0] raw_now;
  // debounce model, run of equal samples per input
  logic [input_count-1:0] last_seen;
  logic [input_count-1:0] clean_now;
  logic [input_count-1:0] clean_last;
  int run_length [input_count];

  // expected controller state
  logic [1:0] mode_model;
  int volume_model;
  logic record_pending;
  logic play_pending;
  int written;
  int take_length;
  int played;
  logic [key_count-1:0] play_keys;
  // words stored during the current take
  logic [key_count-1:0] take_copy [depth];

  assign raw_now = {down_raw, up_raw, play_raw, record_raw, keys_raw};

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  // mode after a sample tick, given the presses waiting for it
  function automatic logic [1:0] next_mode(input logic [1:0] now, input logic record_press,
                                           input logic play_press, input int words,
                                           input int length, input int done_words);
    case (now)
      user_code: begin
        if (record_press) return record_code;
        if (play_press && length != 0) return playback_code;
        return user_code;
      end
      record_code: begin
        // play goes straight on to playback if anything was stored
        if (play_press && words != 0) return playback_code;
        if (record_press || play_press || words == depth) return user_code;
        return record_code;
      end
      default: begin
        if (record_press) return record_code;
        if (done_words == length) return user_code;
        return playback_code;
      end
    endcase
  endfunction

  // one step per press, clamped to 0 and 31
  function automatic int next_volume(input int level, input logic up_press,
                                     input logic down_press);
    if (up_press && !down_press && level < 31) return level + 1;
    if (down_press && !up_press && level > 0) return level - 1;
    return level;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, want, $time);
    end
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
  end

  //////////////////////////////////////////////////////////////////////
  // cycle model and compare on every sample tick
  //////////////////////////////////////////////////////////////////////
  always @(posedge clock) begin
    logic [1:0] mode_next;
    logic record_edge;
    logic play_edge;
    logic up_edge;
    logic down_edge;
    if (reset) begin
      clean_last = clean_now;
      clean_now = raw_now;
      last_seen = raw_now;
      for (int i = 0; i < input_count; i++) begin
        run_length[i] = 1;
      end
      mode_model = user_code;
      volume_model = 8;
      record_pending = 1'b0;
      play_pending = 1'b0;
      written = 0;
      take_length = 0;
      played = 0;
    end else begin
      if (sample_tick) begin
        compare_value("mode", mode, mode_model);
        compare_value("volume", volume, volume_model);
        if (mode_model == playback_code) begin
          compare_value("keys_out", keys_out, play_keys);
        end else begin
          compare_value("keys_out", keys_out, clean_now[key_count-1:0]);
        end
      end
      // rising edges of the clean buttons
      record_edge = clean_now[record_bit] & ~clean_last[record_bit];
      play_edge = clean_now[play_bit] & ~clean_last[play_bit];
      up_edge = clean_now[up_bit] & ~clean_last[up_bit];
      down_edge = clean_now[down_bit] & ~clean_last[down_bit];
      volume_model = next_volume(volume_model, up_edge, down_edge);
      if (sample_tick) begin
        mode_next = next_mode(mode_model, record_pending, play_pending, written,
                              take_length, played);
        if (mode_model == record_code && mode_next != record_code) begin
          take_length = written;
        end
        // the tick that ends a take still stores its word
        if (mode_model == record_code && written < depth) begin
          take_copy[written] = clean_now[key_count-1:0];
          written++;
        end
        if (mode_model == playback_code && played != take_length) begin
          play_keys = take_copy[played];
          played++;
        end
        if (mode_next == record_code && mode_model != record_code) begin
          written = 0;
        end
        if (mode_next == playback_code && mode_model != playback_code) begin
          played = 0;
          play_keys = '0;
        end
        mode_model = mode_next;
        // an edge seen in the tick cycle waits for the following tick
        record_pending = record_edge;
        play_pending = play_edge;
      end else begin
        record_pending = record_pending | record_edge;
        play_pending = play_pending | play_edge;
      end
      clean_last = clean_now;
      // clean follows once stable_cycles + 2 equal samples are seen
      for (int i = 0; i < input_count; i++) begin
        if (raw_now[i] === last_seen[i]) begin
          if (run_length[i] < stable_cycles + 2) run_length[i]++;
        end else begin
          run_length[i] = 1;
        end
        if (run_length[i] >= stable_cycles + 2) clean_now[i] = raw_now[i];
      end
      last_seen = raw_now;
    end
  end

endmodule

/* dv/tb_note_recorder.sv */
`timescale 1ns/1ps

module tb_note_recorder;

  localparam int key_count = 8;
  localparam int addr_width = 4;
  localparam int stable_cycles = 4;
  localparam logic [31:0] seed = 32'h2316_88c6;
  localparam logic [1:0] user_code = 2'd0;
  localparam logic [1:0] record_code = 2'd1;
  localparam logic [1:0] playback_code = 2'd2;
  // button selectors for the stimulus tasks
  localparam int record_button = 0;
  localparam int play_button = 1;
  localparam int up_button = 2;
  localparam int down_button = 3;
  // long enough to pass the debouncer with margin
  localparam int hold_cycles = stable_cycles + 6;

  logic clock;
  logic reset;
  logic sample_tick;
  logic [key_count-1:0] keys_raw;
  logic record_raw;
  logic play_raw;
  logic up_raw;
  logic down_raw;
  logic [key_count-1:0] keys_out;
  logic [1:0] mode;
  logic [4:0] volume;
  // separate generators for keys and tick spacing
  logic [31:0] key_state;
  logic [31:0] tick_state;
  int timeout_count;
  int check_count;
  int error_count;

  note_recorder_top #(
    .key_count(key_count), .addr_width(addr_width), .stable_cycles(stable_cycles)
  ) u_note_recorder_top (
    .clock(clock), .reset(reset), .sample_tick(sample_tick), .keys_raw(keys_raw),
    .record_raw(record_raw), .play_raw(play_raw), .up_raw(up_raw), .down_raw(down_raw),
    .keys_out(keys_out), .mode(mode), .volume(volume));

  tb_checker #(
    .key_count(key_count), .addr_width(addr_width), .stable_cycles(stable_cycles)
  ) u_tb_checker (
    .clock(clock), .reset(reset), .sample_tick(sample_tick), .keys_raw(keys_raw),
    .record_raw(record_raw), .play_raw(play_raw), .up_raw(up_raw), .down_raw(down_raw),
    .keys_out(keys_out), .mode(mode), .volume(volume), .check_count(check_count),
    .error_count(error_count));

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  task automatic new_keys();
    key_state = lcg_step(key_state);
    keys_raw <= key_state[key_count+15:16];
  endtask

  task automatic drive_button(input int button, input logic level);
    case (button)
      record_button: record_raw <= level;
      play_button: play_raw <= level;
      up_button: up_raw <= level;
      default: down_raw <= level;
    endcase
  endtask

  task automatic press_button(input int button);
    drive_button(button, 1'b1);
    repeat (hold_cycles) @(posedge clock);
    drive_button(button, 1'b0);
    repeat (hold_cycles) @(posedge clock);
  endtask

  // pulse one cycle shorter than the hold time
  task automatic glitch_button(input int button);
    drive_button(button, 1'b1);
    repeat (stable_cycles - 1) @(posedge clock);
    drive_button(button, 1'b0);
    repeat (hold_cycles) @(posedge clock);
  endtask

  task automatic glitch_key(input int index);
    keys_raw[index] <= ~keys_raw[index];
    repeat (stable_cycles - 1) @(posedge clock);
    keys_raw[index] <= ~keys_raw[index];
    repeat (hold_cycles) @(posedge clock);
  endtask

  task automatic wait_ticks(input int count);
    int seen;
    int cycles;
    seen = 0;
    cycles = 0;
    while (seen < count && cycles < count * 20) begin
      @(posedge clock);
      cycles++;
      if (sample_tick) seen++;
    end
    if (seen < count) begin
      timeout_count++;
      $display("Timeout: saw %0d of %0d sample ticks at %0t ns", seen, count, $time);
    end
  endtask

  task automatic wait_for_mode(input logic [1:0] code, input int limit);
    int cycles;
    cycles = 0;
    while (mode !== code && cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    if (mode !== code) begin
      timeout_count++;
      $display("Timeout: mode never reached %0d within %0d cycles", code, limit);
    end
  endtask

  // fresh keys before every tick of a take
  task automatic record_keys(input int count);
    repeat (count) begin
      new_keys();
      wait_ticks(1);
    end
  endtask

  task automatic play_take();
    press_button(play_button);
    wait_for_mode(playback_code, 100);
    wait_for_mode(user_code, 600);
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // sample ticks 8 to 15 cycles apart
  initial begin
    int gap;
    tick_state = lcg_step(seed);
    forever begin
      tick_state = lcg_step(tick_state);
      gap = 8 + tick_state[18:16];
      repeat (gap - 1) @(posedge clock);
      sample_tick <= 1'b1;
      @(posedge clock);
      sample_tick <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    timeout_count = 0;
    key_state = lcg_step(seed);
    keys_raw = key_state[key_count+15:16];
    reset = 1'b1;
    sample_tick = 1'b0;
    record_raw = 1'b0;
    play_raw = 1'b0;
    up_raw = 1'b0;
    down_raw = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // live keys pass through in user mode
    record_keys(4);
    // short pulses must be filtered out
    glitch_key(3);
    glitch_button(record_button);
    glitch_button(play_button);
    wait_ticks(2);

    // volume runs into both limits
    repeat (26) press_button(up_button);
    repeat (34) press_button(down_button);
    repeat (2) press_button(up_button);
    wait_ticks(1);

    // record a short take, stop, then replay it
    press_button(record_button);
    wait_for_mode(record_code, 100);
    record_keys(5);
    press_button(record_button);
    wait_for_mode(user_code, 100);
    play_take();

    // fill every address, the take ends by itself
    press_button(record_button);
    wait_for_mode(record_code, 100);
    record_keys(18);
    wait_for_mode(user_code, 100);
    play_take();

    // play press during record switches straight to playback
    press_button(record_button);
    wait_for_mode(record_code, 100);
    record_keys(4);
    press_button(play_button);
    wait_for_mode(playback_code, 100);
    wait_for_mode(user_code, 600);

    // record press during playback starts a new take
    press_button(play_button);
    wait_for_mode(playback_code, 100);
    wait_ticks(2);
    press_button(record_button);
    wait_for_mode(record_code, 100);
    record_keys(3);
    press_button(record_button);
    wait_for_mode(user_code, 100);
    play_take();
    wait_ticks(3);

    $display("checks %0d, value errors %0d, timeouts %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
source/note_pkg.sv
source/key_debouncer.sv
source/volume_control.sv
source/mode_control.sv
source/take_recorder.sv
source/take_player.sv
source/take_store.sv
source/note_recorder_top.sv
dv/tb_checker.sv
dv/tb_note_recorder.sv

/* Bender.yml */
package:
  name: note_recorder

sources:
  - source/note_pkg.sv
  - source/key_debouncer.sv
  - source/volume_control.sv
  - source/mode_control.sv
  - source/take_recorder.sv
  - source/take_player.sv
  - source/take_store.sv
  - source/note_recorder_top.sv
  - target: test
    files:
      - dv/tb_checker.sv
      - dv/tb_note_recorder.sv
